// ==== project.f ====
design/fetch_pkg.sv
design/icache_array.sv
design/icache_ctrl.sv
design/fetch_queue.sv
design/icache_top.sv
tb/mem_model.sv
tb/tb_icache.sv

// ==== Makefile ====
# Verilator flow for the instruction-fetch front end

VERILATOR  ?= verilator
TOP        ?= tb_icache
FILELIST   ?= project.f
BUILD_DIR  ?= build
LOG        ?= sim.log
PASS_TEXT  ?= Finished with no errors
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/tb_icache.sv ====
`timescale 1ns/1ns

module tb_icache import fetch_pkg::*;
();

	localparam int cache_lines = 32;
	localparam int queue_depth = 8;
	localparam int wait_limit  = 3000;
	localparam logic [word_w-1:0] data_key = 64'ha5a5_0f0f_3c3c_9696;

	logic        clock;
	logic        reset;
	logic        mispredict;
	fetch_req_t  fetch_req;
	logic        fetch_ready;
	fetch_resp_t fetch_resp;
	mem_req_t    mem_req;
	mem_resp_t   mem_resp;
	logic        hold_returns;
	logic        force_busy;
	logic        mem_idle;

	// addresses not yet accepted
	logic [addr_w-1:0] feed [$];
	// accepted addresses in request order
	logic [addr_w-1:0] expect_addr [$];
	int                accept_cycle [$];
	logic [addr_w-1:0] flushed [$];
	int                cycle;
	int                errors;
	int                timeouts;
	logic              hit_test;
	logic              busy_test;
	string             test_name;

	icache_top #(
		.cache_lines (cache_lines),
		.queue_depth (queue_depth)
	) u_dut (
		.clock       (clock),
		.reset       (reset),
		.mispredict  (mispredict),
		.fetch_req   (fetch_req),
		.fetch_ready (fetch_ready),
		.fetch_resp  (fetch_resp),
		.mem_req     (mem_req),
		.mem_resp    (mem_resp)
	);

	mem_model u_mem (
		.clock        (clock),
		.reset        (reset),
		.hold_returns (hold_returns),
		.force_busy   (force_busy),
		.mem_req      (mem_req),
		.mem_resp     (mem_resp),
		.idle         (mem_idle)
	);

	always #2 clock = ~clock;

	function automatic logic [addr_w-1:0] line_addr(input logic [addr_w-1:0] base, input int line);
		return base + (addr_w'(line) << 3);
	endfunction

	task automatic report_mismatch(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		errors++;
		$display("CHECK FAILED %s/%s expected %h actual %h", test_name, what, expected, actual);
	endtask

	task automatic check_word();
		assert (expect_addr.size() != 0)
		else
		begin
			errors++;
			$display("%s: word for %h came back with no fetch outstanding", test_name,
				fetch_resp.addr);
		end
		if (expect_addr.size() != 0)
		begin
			assert (fetch_resp.addr == expect_addr[0])
			else
				report_mismatch("return order", expect_addr[0], fetch_resp.addr);
			assert (fetch_resp.data == (expect_addr[0] ^ data_key))
			else
				report_mismatch("word data", expect_addr[0] ^ data_key, fetch_resp.data);
			if (hit_test)
			begin
				assert (cycle - accept_cycle[0] == 2)
				else
					report_mismatch("hit latency", 64'd2, 64'(cycle - accept_cycle[0]));
			end
			void'(expect_addr.pop_front());
			void'(accept_cycle.pop_front());
		end
	endtask

	// processor side of the handshake
	always @(posedge clock)
	begin
		cycle++;
		if (!reset)
		begin
			if (mispredict)
			begin
				expect_addr.delete();
				accept_cycle.delete();
			end
			else if (fetch_resp.valid)
				check_word();
			if (hit_test)
			begin
				assert (mem_req.command != cmd_load)
				else
				begin
					errors++;
					$display("%s: load sent to memory for a cached address", test_name);
				end
			end
			if (busy_test && fetch_req.valid)
			begin
				assert (!fetch_ready)
				else
				begin
					errors++;
					$display("%s: request accepted while memory was busy", test_name);
				end
			end
			if (fetch_req.valid && fetch_ready)
			begin
				expect_addr.push_back(fetch_req.addr);
				accept_cycle.push_back(cycle);
				void'(feed.pop_front());
			end
			assert (expect_addr.size() <= queue_depth)
			else
				report_mismatch("in-flight bound", 64'(queue_depth), 64'(expect_addr.size()));
		end
		fetch_req.valid <= feed.size() != 0;
		fetch_req.addr  <= (feed.size() != 0) ? feed[0] : '0;
	end

	task automatic wait_drained();
		int n;
		n = 0;
		while (((feed.size() != 0) || (expect_addr.size() != 0)) && (n < wait_limit))
		begin
			@(negedge clock);
			n++;
		end
		if (n >= wait_limit)
		begin
			timeouts++;
			$display("timeout: %s still had fetches outstanding", test_name);
		end
	endtask

	task automatic wait_accepted();
		int n;
		n = 0;
		while ((feed.size() != 0) && (n < wait_limit))
		begin
			@(negedge clock);
			n++;
		end
		if (n >= wait_limit)
		begin
			timeouts++;
			$display("timeout: %s requests were never all accepted", test_name);
		end
	endtask

	task automatic wait_mem_idle();
		int n;
		n = 0;
		while (!mem_idle && (n < wait_limit))
		begin
			@(negedge clock);
			n++;
		end
		if (n >= wait_limit)
		begin
			timeouts++;
			$display("timeout: %s memory never went idle", test_name);
		end
	endtask

	// waits for 20 edges in a row with a request held back
	task automatic wait_stalled();
		int n;
		int run;
		n = 0;
		run = 0;
		while ((run < 20) && (n < wait_limit))
		begin
			@(negedge clock);
			n++;
			run = (fetch_req.valid && !fetch_ready) ? run + 1 : 0;
		end
		if (n >= wait_limit)
		begin
			timeouts++;
			$display("timeout: %s request stream never stalled", test_name);
		end
	endtask

	initial
	begin
		clock        = 1'b0;
		reset        = 1'b1;
		mispredict   = 1'b0;
		fetch_req    = '0;
		hold_returns = 1'b0;
		force_busy   = 1'b0;
		hit_test     = 1'b0;
		busy_test    = 1'b0;
		cycle        = 0;
		errors       = 0;
		timeouts     = 0;
		test_name    = "reset";
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);

		test_name = "cold misses";
		for (int i = 0; i < 12; i++)
			feed.push_back(line_addr(64'h1000, i));
		wait_drained();
		wait_mem_idle();

		// the same lines now hit in the cache
		test_name = "hits";
		hit_test = 1'b1;
		for (int i = 0; i < 12; i++)
		begin
			feed.push_back(line_addr(64'h1000, i));
			wait_drained();
		end
		hit_test = 1'b0;

		test_name = "busy memory";
		@(posedge clock);
		force_busy <= 1'b1;
		@(negedge clock);
		busy_test = 1'b1;
		feed.push_back(line_addr(64'h5000, 20));
		wait_stalled();
		busy_test = 1'b0;
		@(posedge clock);
		force_busy <= 1'b0;
		wait_drained();

		test_name = "queue bound";
		@(posedge clock);
		hold_returns <= 1'b1;
		@(negedge clock);
		for (int i = 0; i < 20; i++)
			feed.push_back(line_addr(64'h3000, i));
		wait_stalled();
		// stage register and queue together hold one full queue of misses
		assert (expect_addr.size() == queue_depth)
		else
			report_mismatch("fetches held", 64'(queue_depth), 64'(expect_addr.size()));
		@(posedge clock);
		hold_returns <= 1'b0;
		wait_drained();
		wait_mem_idle();

		test_name = "flush";
		@(posedge clock);
		hold_returns <= 1'b1;
		@(negedge clock);
		for (int i = 0; i < 6; i++)
		begin
			feed.push_back(line_addr(64'h4000, 24 + i));
			flushed.push_back(line_addr(64'h4000, 24 + i));
		end
		wait_accepted();
		@(posedge clock);
		mispredict <= 1'b1;
		@(posedge clock);
		mispredict   <= 1'b0;
		hold_returns <= 1'b0;
		wait_mem_idle();

		// late fills must have reached the cache
		test_name = "refetch after flush";
		hit_test = 1'b1;
		foreach (flushed[i])
		begin
			feed.push_back(flushed[i]);
			wait_drained();
		end
		hit_test = 1'b0;

		@(negedge clock);
		$display("errors: %0d timeouts: %0d", errors, timeouts);
		if ((errors == 0) && (timeouts == 0))
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== tb/mem_model.sv ====
`timescale 1ns/1ns

module mem_model import fetch_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  logic      hold_returns,
	input  logic      force_busy,
	input  mem_req_t  mem_req,
	output mem_resp_t mem_resp,
	output logic      idle
);

	localparam logic [word_w-1:0] data_key = 64'ha5a5_0f0f_3c3c_9696;
	localparam int slots = 2 ** mem_tag_w;

	logic [31:0]          rng;
	logic                 busy_draw;
	logic [slots-1:0]     pend_on;
	logic [addr_w-1:0]    pend_addr [slots];
	int                   pend_wait [slots];
	logic [slots-1:0]     in_use;
	logic [mem_tag_w-1:0] next_tag;
	logic [mem_tag_w-1:0] free_tag;
	logic [mem_tag_w-1:0] pick_start;
	logic [mem_tag_w-1:0] ready_tag;
	logic [mem_tag_w-1:0] offer;
	logic [mem_tag_w-1:0] ret_tag;
	logic [word_w-1:0]    ret_data;
	logic                 taken;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// walks the tags 1..15, skipping 0
	function automatic logic [mem_tag_w-1:0] tag_after(input logic [mem_tag_w-1:0] start,
		input int k);
		int t;
		t = int'(start) + k;
		if (t >= slots)
			t = t - (slots - 1);
		return mem_tag_w'(t);
	endfunction

	// the tag on the bus this cycle is still in use
	always_comb
	begin
		in_use = pend_on;
		in_use[ret_tag] = 1'b1;
		free_tag = '0;
		for (int k = slots - 2; k >= 0; k--)
		begin
			if (!in_use[tag_after(next_tag, k)])
				free_tag = tag_after(next_tag, k);
		end
	end

	// random starting point gives out-of-order returns
	always_comb
	begin
		pick_start = tag_after(mem_tag_w'(1), int'(rng[7:4]) % (slots - 1));
		ready_tag = '0;
		for (int k = slots - 2; k >= 0; k--)
		begin
			if (pend_on[tag_after(pick_start, k)] && (pend_wait[tag_after(pick_start, k)] == 0))
				ready_tag = tag_after(pick_start, k);
		end
	end

	// offer a number every cycle, only a load takes it
	assign offer = (busy_draw || force_busy) ? '0 : free_tag;
	assign taken = (mem_req.command == cmd_load) && (offer != '0);
	assign idle  = (pend_on == '0) && (ret_tag == '0);

	always_comb
	begin
		mem_resp.response = offer;
		mem_resp.tag      = ret_tag;
		mem_resp.data     = ret_data;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			rng       <= 32'h5b18;
			busy_draw <= 1'b0;
			pend_on   <= '0;
			next_tag  <= mem_tag_w'(1);
			ret_tag   <= '0;
			ret_data  <= '0;
		end
		else
		begin
			rng       <= xorshift32(rng);
			busy_draw <= rng[9:8] == 2'b00;
			for (int t = 1; t < slots; t++)
			begin
				if (pend_on[t] && (pend_wait[t] != 0))
					pend_wait[t] <= pend_wait[t] - 1;
			end
			ret_tag <= '0;
			if (!hold_returns && (ready_tag != '0))
			begin
				ret_tag            <= ready_tag;
				ret_data           <= pend_addr[ready_tag] ^ data_key;
				pend_on[ready_tag] <= 1'b0;
			end
			if (taken)
			begin
				pend_on[offer]   <= 1'b1;
				pend_addr[offer] <= mem_req.addr;
				pend_wait[offer] <= 2 + int'(rng[20:16]) % 19;
				next_tag         <= tag_after(offer, 1);
			end
		end
	end

endmodule

// ==== design/icache_top.sv ====
`timescale 1ns/1ns

module icache_top import fetch_pkg::*;
#(
	parameter int cache_lines = 32,
	parameter int queue_depth = 16
)
(
	input  logic        clock,
	input  logic        reset,
	input  logic        mispredict,

	input  fetch_req_t  fetch_req,
	output logic        fetch_ready,
	output fetch_resp_t fetch_resp,

	output mem_req_t    mem_req,
	input  mem_resp_t   mem_resp
);

	logic [addr_w-1:0] lookup_addr;
	logic              hit;
	logic [word_w-1:0] hit_data;
	logic              fill_valid;
	logic [addr_w-1:0] fill_addr;
	logic [word_w-1:0] fill_data;
	queue_entry_t      stage_entry;
	logic              queue_full;

	// lookup stage
	icache_ctrl #(
		.cache_lines (cache_lines)
	) u_ctrl (
		.clock       (clock),
		.reset       (reset),
		.mispredict  (mispredict),
		.fetch_req   (fetch_req),
		.fetch_ready (fetch_ready),
		.mem_req     (mem_req),
		.mem_resp    (mem_resp),
		.queue_full  (queue_full),
		.lookup_addr (lookup_addr),
		.hit         (hit),
		.hit_data    (hit_data),
		.fill_valid  (fill_valid),
		.fill_addr   (fill_addr),
		.fill_data   (fill_data),
		.stage_entry (stage_entry)
	);

	icache_array #(
		.cache_lines (cache_lines)
	) u_array (
		.clock       (clock),
		.reset       (reset),
		.lookup_addr (lookup_addr),
		.hit         (hit),
		.hit_data    (hit_data),
		.fill_valid  (fill_valid),
		.fill_addr   (fill_addr),
		.fill_data   (fill_data)
	);

	// in-order return
	fetch_queue #(
		.queue_depth (queue_depth)
	) u_queue (
		.clock       (clock),
		.reset       (reset),
		.mispredict  (mispredict),
		.stage_entry (stage_entry),
		.mem_resp    (mem_resp),
		.queue_full  (queue_full),
		.fetch_resp  (fetch_resp)
	);

endmodule

// ==== design/fetch_queue.sv ====
`timescale 1ns/1ns

module fetch_queue import fetch_pkg::*;
#(
	parameter int queue_depth = 16
)
(
	input  logic         clock,
	input  logic         reset,
	input  logic         mispredict,

	input  queue_entry_t stage_entry,
	input  mem_resp_t    mem_resp,

	output logic         queue_full,
	output fetch_resp_t  fetch_resp
);

	localparam int ptr_w = $clog2(queue_depth);

	// extra top bit tells full from empty
	logic [ptr_w:0] head;
	logic [ptr_w:0] tail;
	logic [ptr_w:0] used;

	queue_entry_t entries [queue_depth];

	queue_entry_t head_entry;
	queue_entry_t incoming;
	logic         tag_arrived;
	logic         not_empty;
	logic         retire;

	assign used      = tail - head;
	assign not_empty = head != tail;

	// leave room for the entry sitting in the stage register
	assign queue_full = used >= (ptr_w + 1)'(queue_depth - 1);

	assign tag_arrived = mem_resp.tag != '0;

	assign head_entry = entries[head[ptr_w-1:0]];
	assign retire     = not_empty && head_entry.filled;

	always_comb
	begin
		fetch_resp.valid = retire;
		fetch_resp.addr  = head_entry.addr;
		fetch_resp.data  = head_entry.data;
	end

	// data can come back while the miss is still in the stage register
	always_comb
	begin
		incoming = stage_entry;
		if (tag_arrived && !stage_entry.filled && (stage_entry.mem_tag == mem_resp.tag))
		begin
			incoming.filled = 1'b1;
			incoming.data   = mem_resp.data;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset || mispredict)
		begin
			head <= '0;
			tail <= '0;
			for (int i = 0; i < queue_depth; i++)
			begin
				entries[i].valid  <= 1'b0;
				entries[i].filled <= 1'b0;
			end
		end
		else
		begin
			// every waiting entry with this tag picks up the data
			for (int i = 0; i < queue_depth; i++)
			begin
				if (tag_arrived && entries[i].valid && !entries[i].filled
					&& (entries[i].mem_tag == mem_resp.tag))
				begin
					entries[i].filled <= 1'b1;
					entries[i].data   <= mem_resp.data;
				end
			end

			if (retire)
			begin
				entries[head[ptr_w-1:0]].valid  <= 1'b0;
				entries[head[ptr_w-1:0]].filled <= 1'b0;
				head <= head + 1'b1;
			end

			if (stage_entry.valid)
			begin
				entries[tail[ptr_w-1:0]] <= incoming;
				tail <= tail + 1'b1;
			end
		end
	end

endmodule

// ==== design/icache_ctrl.sv ====
`timescale 1ns/1ns

module icache_ctrl import fetch_pkg::*;
#(
	parameter int cache_lines = 32
)
(
	input  logic              clock,
	input  logic              reset,
	input  logic              mispredict,

	input  fetch_req_t        fetch_req,
	output logic              fetch_ready,

	output mem_req_t          mem_req,
	input  mem_resp_t         mem_resp,

	input  logic              queue_full,

	output logic [addr_w-1:0] lookup_addr,
	input  logic              hit,
	input  logic [word_w-1:0] hit_data,

	output logic              fill_valid,
	output logic [addr_w-1:0] fill_addr,
	output logic [word_w-1:0] fill_data,

	output queue_entry_t      stage_entry
);

	localparam int off_w = $clog2(word_w / 8);
	localparam int idx_w = $clog2(cache_lines);
	localparam int tag_w = addr_w - off_w - idx_w;
	localparam int slots = 2 ** mem_tag_w;

	// outstanding loads by memory tag, slot 0 never used
	logic [slots-1:0]  out_valid;
	logic [addr_w-1:0] out_addr [slots];

	logic              same_line;
	logic              same_tag;
	logic              fill_fwd;
	logic              lookup_hit;
	logic [word_w-1:0] lookup_word;
	logic              can_take;
	logic              issue_load;
	logic              accept;

	assign lookup_addr = fetch_req.addr;

	// returning data goes straight back into the array
	assign fill_valid = (mem_resp.tag != '0) && out_valid[mem_resp.tag];
	assign fill_addr  = out_addr[mem_resp.tag];
	assign fill_data  = mem_resp.data;

	// a fill landing on the looked-up word counts as a hit this cycle
	assign same_line   = fill_addr[off_w +: idx_w] == lookup_addr[off_w +: idx_w];
	assign same_tag    = fill_addr[addr_w-1 -: tag_w] == lookup_addr[addr_w-1 -: tag_w];
	assign fill_fwd    = fill_valid && same_line && same_tag;
	assign lookup_hit  = hit || fill_fwd;
	assign lookup_word = fill_fwd ? fill_data : hit_data;

	assign can_take   = fetch_req.valid && !queue_full && !mispredict;
	assign issue_load = can_take && !lookup_hit;

	// a miss only goes ahead once memory hands back a response number
	assign accept      = can_take && (lookup_hit || (mem_resp.response != '0));
	assign fetch_ready = accept;

	always_comb
	begin
		mem_req.command = issue_load ? cmd_load : cmd_none;
		mem_req.addr    = fetch_req.addr;
	end

	// tag table, kept across a flush so late fills still land
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			out_valid <= '0;
		end
		else
		begin
			if (fill_valid)
				out_valid[mem_resp.tag] <= 1'b0;
			if (issue_load && accept)
				out_valid[mem_resp.response] <= 1'b1;
		end
		if (issue_load && accept)
			out_addr[mem_resp.response] <= fetch_req.addr;
	end

	// lookup stage register
	always_ff @(posedge clock)
	begin
		if (reset || mispredict)
			stage_entry.valid <= 1'b0;
		else
			stage_entry.valid <= accept;
		if (accept)
		begin
			stage_entry.filled  <= lookup_hit;
			stage_entry.mem_tag <= lookup_hit ? '0 : mem_resp.response;
			stage_entry.addr    <= fetch_req.addr;
			stage_entry.data    <= lookup_hit ? lookup_word : '0;
		end
	end

endmodule

// ==== design/icache_array.sv ====
`timescale 1ns/1ns

module icache_array import fetch_pkg::*;
#(
	parameter int cache_lines = 32
)
(
	input  logic              clock,
	input  logic              reset,

	input  logic [addr_w-1:0] lookup_addr,
	output logic              hit,
	output logic [word_w-1:0] hit_data,

	input  logic              fill_valid,
	input  logic [addr_w-1:0] fill_addr,
	input  logic [word_w-1:0] fill_data
);

	// one word per line, byte offset below the index
	localparam int off_w = $clog2(word_w / 8);
	localparam int idx_w = $clog2(cache_lines);
	localparam int tag_w = addr_w - off_w - idx_w;

	logic [cache_lines-1:0] line_valid;
	logic [tag_w-1:0]       line_tag [cache_lines];
	logic [word_w-1:0]      line_data [cache_lines];

	logic [idx_w-1:0] lookup_idx;
	logic [tag_w-1:0] lookup_tag;
	logic [idx_w-1:0] fill_idx;
	logic [tag_w-1:0] fill_tag;

	assign lookup_idx = lookup_addr[off_w +: idx_w];
	assign lookup_tag = lookup_addr[addr_w-1 -: tag_w];
	assign fill_idx   = fill_addr[off_w +: idx_w];
	assign fill_tag   = fill_addr[addr_w-1 -: tag_w];

	// combinational read port
	assign hit      = line_valid[lookup_idx] && (line_tag[lookup_idx] == lookup_tag);
	assign hit_data = line_data[lookup_idx];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			line_valid <= '0;
		end
		else if (fill_valid)
		begin
			line_valid[fill_idx] <= 1'b1;
		end
	end

	// fill replaces whatever the line held
	always_ff @(posedge clock)
	begin
		if (fill_valid)
		begin
			line_tag[fill_idx]  <= fill_tag;
			line_data[fill_idx] <= fill_data;
		end
	end

endmodule

// ==== design/fetch_pkg.sv ====
package fetch_pkg;

	// address and instruction word widths
	localparam int addr_w = 64;
	localparam int word_w = 64;

	// tag 0 is reserved for busy / nothing returning
	localparam int mem_tag_w = 4;

	typedef enum logic
	{
		cmd_none = 1'b0,
		cmd_load = 1'b1
	} mem_cmd_e;

	typedef struct packed
	{
		logic              valid;
		logic [addr_w-1:0] addr;
	} fetch_req_t;

	typedef struct packed
	{
		logic              valid;
		logic [addr_w-1:0] addr;
		logic [word_w-1:0] data;
	} fetch_resp_t;

	typedef struct packed
	{
		mem_cmd_e          command;
		logic [addr_w-1:0] addr;
	} mem_req_t;

	// response accepts a load, tag marks returning data
	typedef struct packed
	{
		logic [mem_tag_w-1:0] response;
		logic [mem_tag_w-1:0] tag;
		logic [word_w-1:0]    data;
	} mem_resp_t;

	typedef struct packed
	{
		logic                 valid;
		logic                 filled;
		logic [mem_tag_w-1:0] mem_tag;
		logic [addr_w-1:0]    addr;
		logic [word_w-1:0]    data;
	} queue_entry_t;

endpackage
